//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= ntm_divider_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Run, keep the log, and pass only if the pass line is in it
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
logic/ntm_math_pkg.sv
logic/ntm_ctrl_pkg.sv
logic/ntm_vector_div_if.sv
logic/ntm_scalar_div_if.sv
logic/ntm_scalar_integer_divider.sv
logic/ntm_vector_integer_divider.sv
logic/ntm_matrix_integer_divider.sv
logic/ntm_divider_top.sv
testbench/ntm_divider_tb.sv

//--- logic/ntm_ctrl_pkg.sv
package ntm_ctrl_pkg;

  ////////////////////
  // Matrix walk
  ////////////////////

  // Same four steps as the row/column loop of the matrix unit
  typedef enum logic [1:0] {
    matrix_starter,
    matrix_input_i,
    matrix_input_j,
    matrix_ender
  } matrix_state_t;

  // One row of operands
  typedef enum logic [1:0] {
    vector_idle,
    vector_collect,
    vector_divide,
    vector_emit
  } vector_state_t;

  // Restoring core
  typedef enum logic {
    scalar_idle,
    scalar_busy
  } scalar_state_t;

endpackage

//--- logic/ntm_divider_top.sv
`timescale 1ns/1ps

module ntm_divider_top (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic                 DATA_A_IN_I_ENABLE,
  input  logic                 DATA_A_IN_J_ENABLE,
  input  logic                 DATA_B_IN_I_ENABLE,
  input  logic                 DATA_B_IN_J_ENABLE,
  output logic                 DATA_OUT_I_ENABLE,
  output logic                 DATA_OUT_J_ENABLE,
  input  ntm_math_pkg::index_t SIZE_I_IN,
  input  ntm_math_pkg::index_t SIZE_J_IN,
  input  ntm_math_pkg::data_t  DATA_A_IN,
  input  ntm_math_pkg::data_t  DATA_B_IN,
  output ntm_math_pkg::data_t  DATA_OUT,
  output ntm_math_pkg::data_t  REST_OUT
);

  // Matrix to row, row to scalar core
  ntm_vector_div_if vec_bus ();
  ntm_scalar_div_if scl_bus ();

  ntm_matrix_integer_divider matrix0 (
    .CLK,
    .RST,
    .START,
    .READY,
    .DATA_A_IN_I_ENABLE,
    .DATA_A_IN_J_ENABLE,
    .DATA_B_IN_I_ENABLE,
    .DATA_B_IN_J_ENABLE,
    .DATA_OUT_I_ENABLE,
    .DATA_OUT_J_ENABLE,
    .SIZE_I_IN,
    .SIZE_J_IN,
    .DATA_A_IN,
    .DATA_B_IN,
    .DATA_OUT,
    .REST_OUT,
    .vec (vec_bus)
  );

  ntm_vector_integer_divider vector0 (
    .CLK,
    .RST,
    .unit (vec_bus),
    .div  (scl_bus)
  );

  ntm_scalar_integer_divider scalar0 (
    .CLK,
    .RST,
    .core (scl_bus)
  );

endmodule

//--- logic/ntm_math_pkg.sv
package ntm_math_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Operand width, also the number of restoring steps
  localparam int data_width = 32;

  // Matrix sizes and loop indices
  localparam int index_width = 8;

  // Enough bits to count the restoring steps down to zero
  localparam int step_width = $clog2(data_width);

  ////////////////////
  // Vector types
  ////////////////////

  // Dividend, divisor, quotient and remainder
  typedef logic [data_width-1:0] data_t;

  // SIZE_I, SIZE_J and row/column counters
  typedef logic [index_width-1:0] index_t;

  // Step counter inside the scalar core
  typedef logic [step_width-1:0] step_t;

endpackage

//--- logic/ntm_matrix_integer_divider.sv
`timescale 1ns/1ps

module ntm_matrix_integer_divider (
  input  logic                 CLK,
  input  logic                 RST,
  // Control
  input  logic                 START,
  output logic                 READY,
  input  logic                 DATA_A_IN_I_ENABLE,
  input  logic                 DATA_A_IN_J_ENABLE,
  input  logic                 DATA_B_IN_I_ENABLE,
  input  logic                 DATA_B_IN_J_ENABLE,
  output logic                 DATA_OUT_I_ENABLE,
  output logic                 DATA_OUT_J_ENABLE,
  // Data
  input  ntm_math_pkg::index_t SIZE_I_IN,
  input  ntm_math_pkg::index_t SIZE_J_IN,
  input  ntm_math_pkg::data_t  DATA_A_IN,
  input  ntm_math_pkg::data_t  DATA_B_IN,
  output ntm_math_pkg::data_t  DATA_OUT,
  output ntm_math_pkg::data_t  REST_OUT,
  // Row unit
  ntm_vector_div_if.ctrl       vec
);

  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  matrix_state_t state;
  index_t        index_i;
  index_t        index_j;

  // Operand seen for the current element
  logic got_a;
  logic got_b;

  // Strobes accepted in the current step
  logic a_strobe;
  logic b_strobe;

  logic result_take;
  logic last_row;
  logic row_open;

  // Registered copies toward the row unit
  logic   start_r;
  logic   a_en_r;
  logic   b_en_r;
  index_t size_r;
  data_t  a_r;
  data_t  b_r;

  ////////////////////
  // Decode
  ////////////////////

  // I strobes open a row, J strobes continue it
  always_comb begin
    a_strobe = 1'b0;
    b_strobe = 1'b0;
    if (state == matrix_input_i) begin
      a_strobe = DATA_A_IN_I_ENABLE;
      b_strobe = DATA_B_IN_I_ENABLE;
    end else if (state == matrix_input_j) begin
      a_strobe = DATA_A_IN_J_ENABLE;
      b_strobe = DATA_B_IN_J_ENABLE;
    end
  end

  assign result_take = (state == matrix_ender) && vec.out_enable;
  assign last_row    = index_i == SIZE_I_IN - 1'b1;
  // New row on START, or after a row end that is not the last
  assign row_open    = ((state == matrix_starter) && START) ||
                       (result_take && vec.ready && !last_row);

  ////////////////////
  // Matrix walk
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= matrix_starter;
      index_i           <= '0;
      index_j           <= '0;
      got_a             <= 1'b0;
      got_b             <= 1'b0;
      start_r           <= 1'b0;
      a_en_r            <= 1'b0;
      b_en_r            <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
    end else begin
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      // Forwarded one cycle late
      start_r <= row_open;
      a_en_r  <= a_strobe;
      b_en_r  <= b_strobe;
      case (state)
        matrix_starter: begin
          if (START) begin
            index_i <= '0;
            index_j <= '0;
            state   <= matrix_input_i;
          end
        end
        matrix_input_i, matrix_input_j: begin
          if ((got_a || a_strobe) && (got_b || b_strobe)) begin
            got_a <= 1'b0;
            got_b <= 1'b0;
            state <= matrix_ender;
          end else begin
            got_a <= got_a || a_strobe;
            got_b <= got_b || b_strobe;
          end
        end
        matrix_ender: begin
          if (vec.out_enable) begin
            DATA_OUT_J_ENABLE <= 1'b1;
            if (vec.ready) begin
              // Row end, maybe matrix end too
              DATA_OUT_I_ENABLE <= 1'b1;
              index_j           <= '0;
              if (last_row) begin
                READY <= 1'b1;
                state <= matrix_starter;
              end else begin
                index_i <= index_i + 1'b1;
                state   <= matrix_input_i;
              end
            end else begin
              index_j <= index_j + 1'b1;
              state   <= matrix_input_j;
            end
          end
        end
        default: state <= matrix_starter;
      endcase
    end
  end

  // Operand and result payload
  always_ff @(posedge CLK) begin
    if (row_open) begin
      size_r <= SIZE_J_IN;
    end
    if (a_strobe) begin
      a_r <= DATA_A_IN;
    end
    if (b_strobe) begin
      b_r <= DATA_B_IN;
    end
    if (result_take) begin
      DATA_OUT <= vec.data_out;
      REST_OUT <= vec.rest_out;
    end
  end

  assign vec.start    = start_r;
  assign vec.size     = size_r;
  assign vec.a_enable = a_en_r;
  assign vec.a        = a_r;
  assign vec.b_enable = b_en_r;
  assign vec.b        = b_r;

  ////////////////////
  // Checks
  ////////////////////

  assert property (@(posedge CLK) disable iff (RST)
    (state == matrix_starter && START) |-> (SIZE_I_IN != '0 && SIZE_J_IN != '0))
    else $error("zero matrix size at START");

  // Row unit count agrees with the column walk
  assert property (@(posedge CLK) disable iff (RST)
    (result_take && vec.ready) |-> (index_j == SIZE_J_IN - 1'b1))
    else $error("row end off the last column");

endmodule

//--- logic/ntm_scalar_div_if.sv
`timescale 1ns/1ps

interface ntm_scalar_div_if;

  import ntm_math_pkg::*;

  // Request
  logic  start;
  data_t dividend;
  data_t divisor;

  // Response, held until the next start
  logic  done;
  data_t quotient;
  data_t remainder;

  modport host (output start, dividend, divisor, input done, quotient, remainder);
  modport core (input start, dividend, divisor, output done, quotient, remainder);

endinterface

//--- logic/ntm_scalar_integer_divider.sv
`timescale 1ns/1ps

module ntm_scalar_integer_divider (
  input logic             CLK,
  input logic             RST,
  ntm_scalar_div_if.core  core
);

  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  scalar_state_t state;
  step_t         count;
  logic          done_r;

  // Partial remainder, quotient/dividend shifter, held divisor
  data_t rem_r;
  data_t quo_r;
  data_t divisor_r;

  // One restoring step
  logic [data_width:0] shifted;
  logic [data_width:0] diff;
  logic                fits;

  ////////////////////
  // Restoring step
  ////////////////////

  // Next dividend bit enters the partial remainder
  assign shifted = {rem_r, quo_r[data_width-1]};
  assign diff    = shifted - {1'b0, divisor_r};
  // Zero divisor always fits, so all ones fall out of the shifter
  assign fits    = shifted >= {1'b0, divisor_r};

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= scalar_idle;
      count  <= '0;
      done_r <= 1'b0;
    end else begin
      done_r <= 1'b0;
      case (state)
        scalar_idle: begin
          if (core.start) begin
            count <= step_t'(data_width - 1);
            state <= scalar_busy;
          end
        end
        scalar_busy: begin
          // Last step raises done right behind it
          if (count == '0) begin
            done_r <= 1'b1;
            state  <= scalar_idle;
          end
          count <= count - 1'b1;
        end
        default: state <= scalar_idle;
      endcase
    end
  end

  // Operand load and shift
  always_ff @(posedge CLK) begin
    if (state == scalar_idle && core.start) begin
      rem_r     <= '0;
      quo_r     <= core.dividend;
      divisor_r <= core.divisor;
    end else if (state == scalar_busy) begin
      rem_r <= fits ? diff[data_width-1:0] : shifted[data_width-1:0];
      quo_r <= {quo_r[data_width-2:0], fits};
    end
  end

  assign core.done      = done_r;
  assign core.quotient  = quo_r;
  assign core.remainder = rem_r;

  // Host waits for done before the next request
  assert property (@(posedge CLK) disable iff (RST)
    (state == scalar_busy) |-> !core.start)
    else $error("scalar divider started while busy");

endmodule

//--- logic/ntm_vector_div_if.sv
`timescale 1ns/1ps

interface ntm_vector_div_if;

  import ntm_math_pkg::*;

  // Row control
  logic   start;
  logic   ready;
  index_t size;

  // Operand strobes and data
  logic   a_enable;
  data_t  a;
  logic   b_enable;
  data_t  b;

  // One result per element
  logic   out_enable;
  data_t  data_out;
  data_t  rest_out;

  // Matrix side
  modport ctrl (output start, size, a_enable, a, b_enable, b,
                input  ready, out_enable, data_out, rest_out);

  // Row unit side
  modport unit (input  start, size, a_enable, a, b_enable, b,
                output ready, out_enable, data_out, rest_out);

endinterface

//--- logic/ntm_vector_integer_divider.sv
`timescale 1ns/1ps

module ntm_vector_integer_divider (
  input logic             CLK,
  input logic             RST,
  ntm_vector_div_if.unit  unit,
  ntm_scalar_div_if.host  div
);

  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  vector_state_t state;

  // Elements left in the row
  index_t remaining;

  // Operand held flags, and held or arriving now
  logic have_a;
  logic have_b;
  logic got_a;
  logic got_b;

  // Registered strobes
  logic start_r;
  logic out_en_r;
  logic ready_r;

  // Operands and results
  data_t a_r;
  data_t b_r;
  data_t quo_r;
  data_t rem_r;

  assign got_a = have_a || unit.a_enable;
  assign got_b = have_b || unit.b_enable;

  ////////////////////
  // Row FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= vector_idle;
      remaining <= '0;
      have_a    <= 1'b0;
      have_b    <= 1'b0;
      start_r   <= 1'b0;
      out_en_r  <= 1'b0;
      ready_r   <= 1'b0;
    end else begin
      // Single-cycle strobes
      start_r  <= 1'b0;
      out_en_r <= 1'b0;
      ready_r  <= 1'b0;
      case (state)
        vector_idle: begin
          if (unit.start) begin
            remaining <= unit.size;
            have_a    <= 1'b0;
            have_b    <= 1'b0;
            state     <= vector_collect;
          end
        end
        vector_collect: begin
          // A and B may come in either order or together
          if (got_a && got_b) begin
            have_a  <= 1'b0;
            have_b  <= 1'b0;
            start_r <= 1'b1;
            state   <= vector_divide;
          end else begin
            have_a <= got_a;
            have_b <= got_b;
          end
        end
        vector_divide: begin
          if (div.done) begin
            out_en_r  <= 1'b1;
            // Row end rides on the last element
            ready_r   <= remaining == index_t'(1);
            remaining <= remaining - 1'b1;
            state     <= vector_emit;
          end
        end
        vector_emit: begin
          state <= (remaining == '0) ? vector_idle : vector_collect;
        end
        default: state <= vector_idle;
      endcase
    end
  end

  // Operand latch and result capture
  always_ff @(posedge CLK) begin
    if (unit.a_enable) begin
      a_r <= unit.a;
    end
    if (unit.b_enable) begin
      b_r <= unit.b;
    end
    if (state == vector_divide && div.done) begin
      quo_r <= div.quotient;
      rem_r <= div.remainder;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign div.start    = start_r;
  assign div.dividend = a_r;
  assign div.divisor  = b_r;

  assign unit.out_enable = out_en_r;
  assign unit.ready      = ready_r;
  assign unit.data_out   = quo_r;
  assign unit.rest_out   = rem_r;

  // Strobes only while a pair is being gathered
  assert property (@(posedge CLK) disable iff (RST)
    (unit.a_enable || unit.b_enable) |-> (state == vector_collect))
    else $error("operand strobe outside collect");

endmodule

//--- testbench/ntm_divider_tb.sv
`timescale 1ns/1ps

module ntm_divider_tb;

  import ntm_math_pkg::*;

  ////////////////////
  // Test table
  ////////////////////

  // Operand fill modes
  localparam int fill_fixed  = 0;
  localparam int fill_random = 1;
  localparam int fill_zero   = 2;

  localparam int num_cases  = 6;
  // Cycles allowed for one element result
  localparam int wait_limit = 200;

  // Skew above zero lets A lead, below zero lets B lead
  typedef struct packed {
    int size_i;
    int size_j;
    int fill;
    int skew;
  } case_t;

  case_t cases [num_cases];

  ////////////////////
  // DUT signals
  ////////////////////

  logic   CLK;
  logic   RST;
  logic   START;
  logic   READY;
  logic   DATA_A_IN_I_ENABLE;
  logic   DATA_A_IN_J_ENABLE;
  logic   DATA_B_IN_I_ENABLE;
  logic   DATA_B_IN_J_ENABLE;
  logic   DATA_OUT_I_ENABLE;
  logic   DATA_OUT_J_ENABLE;
  index_t SIZE_I_IN;
  index_t SIZE_J_IN;
  data_t  DATA_A_IN;
  data_t  DATA_B_IN;
  data_t  DATA_OUT;
  data_t  REST_OUT;

  int     errors;
  int     checks;
  int     j_seen;
  int     i_seen;
  int     ready_seen;
  bit     aborted;
  integer seed;

  ntm_divider_top dut0 (
    .CLK                (CLK),
    .RST                (RST),
    .START              (START),
    .READY              (READY),
    .DATA_A_IN_I_ENABLE (DATA_A_IN_I_ENABLE),
    .DATA_A_IN_J_ENABLE (DATA_A_IN_J_ENABLE),
    .DATA_B_IN_I_ENABLE (DATA_B_IN_I_ENABLE),
    .DATA_B_IN_J_ENABLE (DATA_B_IN_J_ENABLE),
    .DATA_OUT_I_ENABLE  (DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE  (DATA_OUT_J_ENABLE),
    .SIZE_I_IN          (SIZE_I_IN),
    .SIZE_J_IN          (SIZE_J_IN),
    .DATA_A_IN          (DATA_A_IN),
    .DATA_B_IN          (DATA_B_IN),
    .DATA_OUT           (DATA_OUT),
    .REST_OUT           (REST_OUT)
  );

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Running totals of output strobes, sampled mid-cycle
  always @(negedge CLK) begin
    if (DATA_OUT_J_ENABLE) j_seen <= j_seen + 1;
    if (DATA_OUT_I_ENABLE) i_seen <= i_seen + 1;
    if (READY) ready_seen <= ready_seen + 1;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  // Zero divisor gives all ones
  function automatic data_t expect_quo(input data_t a, input data_t b);
    if (b == '0) return '1;
    return a / b;
  endfunction

  // Zero divisor hands back the dividend
  function automatic data_t expect_rem(input data_t a, input data_t b);
    if (b == '0) return a;
    return a % b;
  endfunction

  task automatic make_operands(input int fill, input int i, input int j,
                               output data_t a, output data_t b);
    data_t rnd;
    case (fill)
      fill_fixed: begin
        a = 32'h8000_0000 + data_t'(i * 4099 + j * 257);
        b = data_t'(i * 3 + j + 2);
      end
      fill_zero: begin
        rnd = $random(seed);
        a   = rnd;
        // Every other element divides by zero
        b   = ((i + j) % 2 == 0) ? '0 : data_t'(j + 7);
      end
      default: begin
        a   = $random(seed);
        rnd = $random(seed);
        // Mix of narrow and wide divisors
        b   = j[0] ? (rnd & 32'h0000_00ff) : (rnd >> 3);
      end
    endcase
  endtask

  task automatic set_a(input bit row_first, input logic v);
    if (row_first) DATA_A_IN_I_ENABLE = v;
    else DATA_A_IN_J_ENABLE = v;
  endtask

  task automatic set_b(input bit row_first, input logic v);
    if (row_first) DATA_B_IN_I_ENABLE = v;
    else DATA_B_IN_J_ENABLE = v;
  endtask

  // One operand pair, strobes skewed by |skew| cycles
  task automatic send_pair(input bit row_first, input int skew, input data_t a, input data_t b);
    int gap;
    gap = (skew < 0) ? -skew : skew;
    DATA_A_IN = a;
    DATA_B_IN = b;
    if (skew >= 0) set_a(row_first, 1'b1);
    if (skew <= 0) set_b(row_first, 1'b1);
    @(negedge CLK);
    set_a(row_first, 1'b0);
    set_b(row_first, 1'b0);
    if (skew != 0) begin
      repeat (gap - 1) @(negedge CLK);
      // Trailing operand
      if (skew > 0) set_b(row_first, 1'b1);
      else set_a(row_first, 1'b1);
      @(negedge CLK);
      set_a(row_first, 1'b0);
      set_b(row_first, 1'b0);
    end
  endtask

  task automatic wait_result(input string what, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < wait_limit; n++) begin
      @(negedge CLK);
      if (DATA_OUT_J_ENABLE) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      errors++;
      $display("Timeout: no result strobe for %s", what);
    end
  endtask

  // Outputs quiet between matrices
  task automatic idle_check(input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      check_value("READY idle", data_t'(READY), '0);
      check_value("DATA_OUT_I_ENABLE idle", data_t'(DATA_OUT_I_ENABLE), '0);
      check_value("DATA_OUT_J_ENABLE idle", data_t'(DATA_OUT_J_ENABLE), '0);
    end
  endtask

  ////////////////////
  // One matrix
  ////////////////////

  task automatic run_case(input int k);
    case_t c;
    data_t a;
    data_t b;
    int    i;
    int    j;
    int    j_base;
    int    i_base;
    int    r_base;
    bit    ok;
    bit    last;
    c      = cases[k];
    j_base = j_seen;
    i_base = i_seen;
    r_base = ready_seen;
    $display("Case %0d: %0dx%0d fill %0d skew %0d", k, c.size_i, c.size_j, c.fill, c.skew);
    SIZE_I_IN = index_t'(c.size_i);
    SIZE_J_IN = index_t'(c.size_j);
    START     = 1'b1;
    @(negedge CLK);
    START = 1'b0;
    for (i = 0; i < c.size_i; i++) begin
      for (j = 0; j < c.size_j; j++) begin
        make_operands(c.fill, i, j, a, b);
        send_pair(j == 0, c.skew, a, b);
        wait_result($sformatf("element %0d,%0d of case %0d", i, j, k), ok);
        if (!ok) begin
          aborted = 1'b1;
          return;
        end
        last = (i == c.size_i - 1) && (j == c.size_j - 1);
        check_value($sformatf("DATA_OUT[%0d][%0d]", i, j), DATA_OUT, expect_quo(a, b));
        check_value($sformatf("REST_OUT[%0d][%0d]", i, j), REST_OUT, expect_rem(a, b));
        check_value($sformatf("DATA_OUT_I_ENABLE[%0d][%0d]", i, j),
                    data_t'(DATA_OUT_I_ENABLE), data_t'(j == c.size_j - 1));
        check_value($sformatf("READY[%0d][%0d]", i, j), data_t'(READY), data_t'(last));
      end
    end
    // Let the counters settle, then compare strobe totals
    idle_check(3);
    check_value("DATA_OUT_J_ENABLE count", data_t'(j_seen - j_base),
                data_t'(c.size_i * c.size_j));
    check_value("DATA_OUT_I_ENABLE count", data_t'(i_seen - i_base), data_t'(c.size_i));
    check_value("READY count", data_t'(ready_seen - r_base), data_t'(1));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int k;
    errors     = 0;
    checks     = 0;
    j_seen     = 0;
    i_seen     = 0;
    ready_seen = 0;
    aborted    = 1'b0;
    seed       = 32'h407b_73a8;
    RST                = 1'b1;
    START              = 1'b0;
    DATA_A_IN_I_ENABLE = 1'b0;
    DATA_A_IN_J_ENABLE = 1'b0;
    DATA_B_IN_I_ENABLE = 1'b0;
    DATA_B_IN_J_ENABLE = 1'b0;
    SIZE_I_IN          = '0;
    SIZE_J_IN          = '0;
    DATA_A_IN          = '0;
    DATA_B_IN          = '0;
    // Shapes, fills and A/B skews
    cases[0] = '{1, 1, fill_random, 0};
    cases[1] = '{3, 4, fill_random, 0};
    cases[2] = '{2, 3, fill_zero, 0};
    cases[3] = '{2, 2, fill_random, 2};
    cases[4] = '{2, 2, fill_random, -3};
    cases[5] = '{1, 3, fill_fixed, 0};
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    // Nothing may come out before START
    idle_check(4);
    for (k = 0; k < num_cases; k++) begin
      if (!aborted) run_case(k);
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
